// ==== include/mxint_consts.svh ====
`ifndef MXINT_CONSTS_SVH
`define MXINT_CONSTS_SVH

// ================================================
// Input layer format
// ================================================

`define MX_IN_MAN_WIDTH 8
`define MX_IN_EXP_WIDTH 6

// ================================================
// Output layer format
// ================================================

`define MX_OUT_MAN_WIDTH 4
`define MX_OUT_EXP_WIDTH 5

// Elements sharing one exponent
`define MX_BLOCK_SIZE 4

// Exponent biases, 2**(w-1) - 1
`define MX_IN_BIAS ((1 << (`MX_IN_EXP_WIDTH - 1)) - 1)
`define MX_OUT_BIAS ((1 << (`MX_OUT_EXP_WIDTH - 1)) - 1)

// Leading-one position plus one, zero for an all-zero block
`define MX_LOG2_WIDTH ($clog2(`MX_IN_MAN_WIDTH) + 1)

// Blocks held while the log2 stage works
`define MX_BUF_DEPTH 2

`endif

// ==== hdl/mxint_in_pkg.sv ====
`include "mxint_consts.svh"

package mxint_in_pkg;

  // One signed input mantissa
  typedef logic signed [`MX_IN_MAN_WIDTH-1:0] in_man_t;

  // Biased shared exponent of the input layer
  typedef logic [`MX_IN_EXP_WIDTH-1:0] in_exp_t;

  // Whole input block, kept packed so the block queue
  // can store it as a single word
  typedef struct packed {
    in_man_t [`MX_BLOCK_SIZE-1:0] mant;
    in_exp_t                      expo;
  } in_block_t;

endpackage

// ==== hdl/mxint_out_pkg.sv ====
`include "mxint_consts.svh"

package mxint_out_pkg;

  // One signed output mantissa
  typedef logic signed [`MX_OUT_MAN_WIDTH-1:0] out_man_t;

  // Biased shared exponent of the output layer
  typedef logic [`MX_OUT_EXP_WIDTH-1:0] out_exp_t;

  // All mantissas of one output block
  typedef out_man_t out_man_arr_t [`MX_BLOCK_SIZE-1:0];

  // Bit count of the largest magnitude in a block
  typedef logic [`MX_LOG2_WIDTH-1:0] log2_t;

endpackage

// ==== hdl/log2_max_abs.sv ====
`timescale 1ns/1ns

`include "mxint_consts.svh"

module log2_max_abs
  import mxint_in_pkg::*;
  import mxint_out_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  in_man_t data_in [`MX_BLOCK_SIZE-1:0],
  input  logic    data_in_valid,
  output logic    data_in_ready,

  output log2_t   data_out,
  output logic    data_out_valid,
  input  logic    data_out_ready
);

  localparam int W = `MX_IN_MAN_WIDTH;

  logic [W-1:0] mag [`MX_BLOCK_SIZE];
  logic [W-1:0] or_word;
  log2_t        lead;
  log2_t        log2_q;
  logic         valid_q;

  // Magnitudes, the most negative value maps to 2**(W-1) unsigned
  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_abs
    assign mag[i] = data_in[i][W-1] ? -data_in[i] : data_in[i];
  end

  // The highest set bit of the OR equals that of the largest magnitude
  always_comb begin
    or_word = '0;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      or_word = or_word | mag[i];
    end
  end

  // Ascending scan, so the last hit is the leading one
  always_comb begin
    lead = '0;
    for (int b = 0; b < W; b++) begin
      if (or_word[b]) begin
        lead = log2_t'(b + 1);
      end
    end
  end

  // Single output register, refilled when empty or being drained
  assign data_in_ready = !valid_q || data_out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (data_in_ready) begin
      valid_q <= data_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (data_in_valid && data_in_ready) begin
      log2_q <= lead;
    end
  end

  assign data_out       = log2_q;
  assign data_out_valid = valid_q;

endmodule

// ==== hdl/mx_block_fifo.sv ====
`timescale 1ns/1ns

module mx_block_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst_n,

  input  payload_t wr_data,
  input  logic     wr_valid,
  output logic     wr_ready,

  output payload_t rd_data,
  output logic     rd_valid,
  input  logic     rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointer increment with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign wr_ready = (count != CNT_W'(DEPTH));
  assign rd_valid = (count != '0);

  assign push = wr_valid && wr_ready;
  assign pop  = rd_valid && rd_ready;

  // Head is read straight from storage, visible the cycle after a push
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/mxint_cast.sv ====
`timescale 1ns/1ns

`include "mxint_consts.svh"

module mxint_cast
  import mxint_in_pkg::*;
  import mxint_out_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  in_man_t      mdata_in [`MX_BLOCK_SIZE-1:0],
  input  in_exp_t      edata_in,
  input  logic         data_in_valid,
  output logic         data_in_ready,

  output out_man_arr_t mdata_out,
  output out_exp_t     edata_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);

  // Widest exponent operand plus headroom for the signed sum
  localparam int WIDE_EXP   = (`MX_IN_EXP_WIDTH > `MX_OUT_EXP_WIDTH) ?
                              `MX_IN_EXP_WIDTH : `MX_OUT_EXP_WIDTH;
  localparam int EXP_FULL_W = ((WIDE_EXP > `MX_LOG2_WIDTH) ? WIDE_EXP : `MX_LOG2_WIDTH) + 2;
  localparam int SHIFT_W    = EXP_FULL_W + 2;
  localparam int LIM_W      = `MX_IN_MAN_WIDTH + `MX_OUT_MAN_WIDTH;
  localparam int EXP_CEIL   = 1 << `MX_OUT_EXP_WIDTH;

  localparam logic signed [EXP_FULL_W-1:0] EXP_OFFSET =
    EXP_FULL_W'(2 - `MX_IN_MAN_WIDTH - `MX_IN_BIAS + `MX_OUT_BIAS);
  localparam logic signed [SHIFT_W-1:0] SHIFT_OFFSET = SHIFT_W'(`MX_OUT_MAN_WIDTH - 2);
  localparam logic signed [SHIFT_W-1:0] LIMIT_BASE   = SHIFT_W'(`MX_OUT_MAN_WIDTH - 1);

  localparam out_man_t SAT_POS = out_man_t'((1 << (`MX_OUT_MAN_WIDTH - 1)) - 1);
  localparam out_man_t SAT_NEG = out_man_t'(-((1 << (`MX_OUT_MAN_WIDTH - 1)) - 1));

  logic      log2_in_valid;
  logic      log2_in_ready;
  log2_t     log2_val;
  logic      log2_out_valid;
  logic      log2_out_ready;

  in_block_t wr_blk;
  logic      fifo_wr_valid;
  logic      fifo_wr_ready;
  in_block_t rd_blk;
  logic      fifo_rd_valid;
  logic      fifo_rd_ready;

  logic signed [EXP_FULL_W-1:0] e_full;
  logic signed [SHIFT_W-1:0]    shift;
  logic signed [SHIFT_W-1:0]    neg_shift;
  logic signed [SHIFT_W-1:0]    limit_sh;
  logic        [LIM_W-1:0]      limit;

  // ================================================
  // Split: both branches take the block on one edge
  // ================================================

  assign data_in_ready = log2_in_ready && fifo_wr_ready;
  assign log2_in_valid = data_in_valid && data_in_ready;
  assign fifo_wr_valid = data_in_valid && data_in_ready;

  always_comb begin
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      wr_blk.mant[i] = mdata_in[i];
    end
    wr_blk.expo = edata_in;
  end

  log2_max_abs i_log2 (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (mdata_in),
    .data_in_valid  (log2_in_valid),
    .data_in_ready  (log2_in_ready),
    .data_out       (log2_val),
    .data_out_valid (log2_out_valid),
    .data_out_ready (log2_out_ready)
  );

  mx_block_fifo #(
    .payload_t (in_block_t),
    .DEPTH     (`MX_BUF_DEPTH)
  ) i_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_data  (wr_blk),
    .wr_valid (fifo_wr_valid),
    .wr_ready (fifo_wr_ready),
    .rd_data  (rd_blk),
    .rd_valid (fifo_rd_valid),
    .rd_ready (fifo_rd_ready)
  );

  // ================================================
  // Join: pop both sides on the output handshake
  // ================================================

  assign data_out_valid = log2_out_valid && fifo_rd_valid;
  assign log2_out_ready = data_out_ready && data_out_valid;
  assign fifo_rd_ready  = data_out_ready && data_out_valid;

  // ================================================
  // Exponent rebias and clamp
  // ================================================

  assign e_full = $signed(EXP_FULL_W'(log2_val)) + $signed(EXP_FULL_W'(rd_blk.expo))
                + EXP_OFFSET;

  always_comb begin
    if (log2_val == '0) begin
      edata_out = '0;
    end else if (e_full >= EXP_CEIL) begin
      edata_out = '1;
    end else if (e_full < 0) begin
      edata_out = '0;
    end else begin
      edata_out = e_full[`MX_OUT_EXP_WIDTH-1:0];
    end
  end

  // Clamping loss on the exponent moves into the mantissa shift
  assign shift = SHIFT_W'(e_full) - $signed(SHIFT_W'(edata_out))
               - $signed(SHIFT_W'(log2_val)) + SHIFT_OFFSET;
  assign neg_shift = -shift;

  // Smallest magnitude that no longer fits after the shift
  assign limit_sh = LIMIT_BASE - shift;
  assign limit    = LIM_W'(1'b1) << limit_sh;

  // ================================================
  // Per-element shift with symmetric saturation
  // ================================================

  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_elem
    in_man_t                           m;
    logic        [`MX_IN_MAN_WIDTH-1:0] mag;
    logic signed [LIM_W-1:0]            m_wide;
    out_man_t                          res;

    assign m      = rd_blk.mant[i];
    assign mag    = m[`MX_IN_MAN_WIDTH-1] ? -m : m;
    assign m_wide = LIM_W'(m);

    always_comb begin
      if (m == '0) begin
        res = '0;
      end else if (shift >= `MX_OUT_MAN_WIDTH) begin
        res = m[`MX_IN_MAN_WIDTH-1] ? SAT_NEG : SAT_POS;
      end else if (neg_shift >= `MX_IN_MAN_WIDTH) begin
        // Everything shifted out, sign survives as -1
        res = m[`MX_IN_MAN_WIDTH-1] ? '1 : '0;
      end else if (LIM_W'(mag) >= limit) begin
        res = m[`MX_IN_MAN_WIDTH-1] ? SAT_NEG : SAT_POS;
      end else if (!shift[SHIFT_W-1]) begin
        res = out_man_t'(m_wide <<< shift);
      end else begin
        res = out_man_t'(m_wide >>> neg_shift);
      end
    end

    assign mdata_out[i] = res;
  end

endmodule

// ==== hdl/mxint_cast_top.sv ====
`timescale 1ns/1ns

`include "mxint_consts.svh"

module mxint_cast_top
  import mxint_in_pkg::*;
  import mxint_out_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  // Wide, unnormalized block in
  input  in_man_t      mdata_in [`MX_BLOCK_SIZE-1:0],
  input  in_exp_t      edata_in,
  input  logic         data_in_valid,
  output logic         data_in_ready,

  // Narrow, normalized block out
  output out_man_arr_t mdata_out,
  output out_exp_t     edata_out,
  output logic         data_out_valid,
  input  logic         data_out_ready
);

  mxint_cast i_cast (
    .clk            (clk),
    .rst_n          (rst_n),
    .mdata_in       (mdata_in),
    .edata_in       (edata_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period, first rising edge at 4 ns
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Two rising edges in reset, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verification/mxint_cast_properties.sv ====
`timescale 1ns/1ns

`include "mxint_consts.svh"

module mxint_cast_properties
  import mxint_out_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  input logic         data_in_valid,
  input logic         data_in_ready,
  input logic         data_out_valid,
  input logic         data_out_ready,
  input out_exp_t     edata_out,
  input out_man_arr_t mdata_out
);

  localparam int W = `MX_OUT_MAN_WIDTH;

  int fail_count = 0;

  logic [`MX_BLOCK_SIZE*W-1:0] mdata_flat;

  always_comb begin
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      mdata_flat[i*W +: W] = mdata_out[i];
    end
  end

  // Stalled output keeps its block
  output_held: assert property (@(posedge clk) disable iff (!rst_n)
      data_out_valid && !data_out_ready |=>
      data_out_valid && $stable(edata_out) && $stable(mdata_flat))
    else begin
      $error("output block changed while data_out_ready was low");
      fail_count++;
    end

  // No block enters or leaves without a handshake
  no_move_without_handshake: assert property (@(posedge clk) disable iff (!rst_n)
      !(data_in_valid && data_in_ready) && !(data_out_valid && data_out_ready) |=>
      $stable(data_out_valid))
    else begin
      $error("block taken or dropped without a handshake");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge clk)
      !rst_n |=> !data_out_valid && data_in_ready)
    else begin
      $error("handshake not idle after reset");
      fail_count++;
    end

endmodule

bind mxint_cast mxint_cast_properties i_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .data_in_valid  (data_in_valid),
  .data_in_ready  (data_in_ready),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready),
  .edata_out      (edata_out),
  .mdata_out      (mdata_out)
);

// ==== verification/mxint_cast_tb.sv ====
`timescale 1ns/1ns

`include "mxint_consts.svh"

module mxint_cast_tb
  import mxint_in_pkg::*;
  import mxint_out_pkg::*;
();

  localparam int BLK        = `MX_BLOCK_SIZE;
  localparam int KIND_RAND  = 0;
  localparam int KIND_ZERO  = 1;
  localparam int KIND_LARGE = 2;
  localparam int KIND_SMALL = 3;
  localparam int TOTAL      = 60 + 4 + 8 + 8 + 80 + 20;
  localparam int TIMEOUT_NS = TOTAL * 20 * 8 + 2000;

  typedef struct packed {
    out_exp_t                 expo;
    out_man_t [BLK-1:0]       mant;
  } out_block_t;

  logic         clk;
  logic         rst_n;
  in_man_t      mdata_in [BLK-1:0];
  in_exp_t      edata_in;
  logic         data_in_valid;
  logic         data_in_ready;
  out_man_arr_t mdata_out;
  out_exp_t     edata_out;
  logic         data_out_valid;
  logic         data_out_ready;

  out_block_t exp_q[$];
  int         cyc_q[$];
  bit         timed_q[$];
  int         cycle = 0;
  int         errors = 0;
  int         checks = 0;
  int         n_in = 0;
  int         n_out = 0;
  bit         hold_ready = 1'b1;

  tb_clock_gen i_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mxint_cast_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .mdata_in       (mdata_in),
    .edata_in       (edata_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // ================================================
  // Reference model of the requantization rule
  // ================================================

  function automatic out_block_t ref_cast(input in_block_t blk);
    out_block_t r;
    int m, a, max_abs, l, f, eo, s, lim, v, sat;
    max_abs = 0;
    for (int i = 0; i < BLK; i++) begin
      m = int'($signed(blk.mant[i]));
      a = (m < 0) ? -m : m;
      if (a > max_abs) begin
        max_abs = a;
      end
    end
    l = 0;
    for (int b = 0; b < 16; b++) begin
      if (max_abs >= (1 << b)) begin
        l = b + 1;
      end
    end
    f = l - `MX_IN_MAN_WIDTH + 2 + int'(blk.expo) - `MX_IN_BIAS + `MX_OUT_BIAS;
    if (l == 0 || f < 0) begin
      eo = 0;
    end else if (f >= (1 << `MX_OUT_EXP_WIDTH)) begin
      eo = (1 << `MX_OUT_EXP_WIDTH) - 1;
    end else begin
      eo = f;
    end
    r.expo = out_exp_t'(eo);
    s   = (f - eo) + `MX_OUT_MAN_WIDTH - l - 2;
    sat = (1 << (`MX_OUT_MAN_WIDTH - 1)) - 1;
    for (int i = 0; i < BLK; i++) begin
      m = int'($signed(blk.mant[i]));
      a = (m < 0) ? -m : m;
      lim = 1 << (`MX_OUT_MAN_WIDTH - s - 1);
      if (m == 0) begin
        v = 0;
      end else if (s >= `MX_OUT_MAN_WIDTH) begin
        v = (m < 0) ? -sat : sat;
      end else if (-s >= `MX_IN_MAN_WIDTH) begin
        v = (m < 0) ? -1 : 0;
      end else if (a >= lim) begin
        v = (m < 0) ? -sat : sat;
      end else if (s >= 0) begin
        v = m <<< s;
      end else begin
        v = m >>> (-s);
      end
      r.mant[i] = out_man_t'(v);
    end
    return r;
  endfunction

  function automatic in_block_t make_block(input int kind);
    in_block_t b;
    for (int i = 0; i < BLK; i++) begin
      case (kind)
        KIND_ZERO:  b.mant[i] = '0;
        KIND_SMALL: b.mant[i] = in_man_t'(int'($urandom_range(0, 15)) - 8);
        default:    b.mant[i] = in_man_t'($urandom);
      endcase
    end
    case (kind)
      KIND_LARGE: b.expo = in_exp_t'($urandom_range((1 << `MX_IN_EXP_WIDTH) - 6,
                                                     (1 << `MX_IN_EXP_WIDTH) - 1));
      KIND_SMALL: b.expo = in_exp_t'($urandom_range(0, 8));
      default:    b.expo = in_exp_t'($urandom);
    endcase
    return b;
  endfunction

  // Falling-edge driver; handshake decided 1 ns before the rising edge
  task automatic send_blocks(input int n, input int kind, input bit rand_ready);
    in_block_t b;
    for (int k = 0; k < n; k++) begin
      b = make_block(kind);
      @(negedge clk);
      for (int i = 0; i < BLK; i++) begin
        mdata_in[i] = b.mant[i];
      end
      edata_in       = b.expo;
      data_in_valid  = 1'b1;
      data_out_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      #3;
      while (!data_in_ready) begin
        @(negedge clk);
        data_out_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        #3;
      end
      // Occasional idle cycle between blocks
      if ($urandom_range(0, 3) == 0) begin
        @(negedge clk);
        data_in_valid  = 1'b0;
        data_out_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      end
    end
    @(negedge clk);
    data_in_valid  = 1'b0;
    data_out_ready = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // ================================================
  // Compare outputs against the model
  // ================================================

  initial begin : compare_proc
    in_block_t  blk;
    out_block_t want;
    int         in_cyc;
    bit         timed;
    forever begin
      @(negedge clk);
      #3;
      if (rst_n && data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: output block with no input pending", $time);
          errors++;
        end else begin
          want   = exp_q.pop_front();
          in_cyc = cyc_q.pop_front();
          timed  = timed_q.pop_front();
          checks++;
          if (edata_out !== want.expo) begin
            $display("FAIL %0t: block %0d edata_out %0d, expected %0d",
                     $time, n_out, edata_out, want.expo);
            errors++;
          end
          for (int i = 0; i < BLK; i++) begin
            checks++;
            if (mdata_out[i] !== want.mant[i]) begin
              $display("FAIL %0t: block %0d mdata_out[%0d] %0d, expected %0d",
                       $time, n_out, i, mdata_out[i], want.mant[i]);
              errors++;
            end
          end
          if (timed && cycle != in_cyc + 1) begin
            $display("FAIL %0t: block %0d latency %0d cycles, expected 1",
                     $time, n_out, cycle - in_cyc);
            errors++;
          end
          n_out++;
        end
      end
      if (rst_n && data_in_valid && data_in_ready) begin
        for (int i = 0; i < BLK; i++) begin
          blk.mant[i] = mdata_in[i];
        end
        blk.expo = edata_in;
        exp_q.push_back(ref_cast(blk));
        cyc_q.push_back(cycle);
        timed_q.push_back(hold_ready);
        n_in++;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the DUT stopped passing blocks", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int prop_fails;
    void'($urandom(32'hd947ef49));
    for (int i = 0; i < BLK; i++) begin
      mdata_in[i] = '0;
    end
    edata_in       = '0;
    data_in_valid  = 1'b0;
    data_out_ready = 1'b1;

    @(posedge rst_n);
    @(negedge clk);
    #3;
    if (data_out_valid !== 1'b0) begin
      $display("FAIL %0t: data_out_valid high after reset", $time);
      errors++;
    end
    if (data_in_ready !== 1'b1) begin
      $display("FAIL %0t: data_in_ready low after reset", $time);
      errors++;
    end

    hold_ready = 1'b1;
    send_blocks(60, KIND_RAND, 1'b0);
    send_blocks(4, KIND_ZERO, 1'b0);
    send_blocks(8, KIND_LARGE, 1'b0);
    send_blocks(8, KIND_SMALL, 1'b0);
    hold_ready = 1'b0;
    send_blocks(80, KIND_RAND, 1'b1);
    hold_ready = 1'b1;
    send_blocks(20, KIND_RAND, 1'b0);
    repeat (2) @(negedge clk);

    if (n_in != TOTAL || n_out != n_in) begin
      $display("Error: %0d blocks sent, %0d accepted, %0d returned", TOTAL, n_in, n_out);
      errors++;
    end
    prop_fails = i_dut.i_cast.i_props.fail_count;
    $display("Blocks %0d, checks %0d, errors %0d, assertion failures %0d",
             n_out, checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
hdl/mxint_in_pkg.sv
hdl/mxint_out_pkg.sv
hdl/log2_max_abs.sv
hdl/mx_block_fifo.sv
hdl/mxint_cast.sv
hdl/mxint_cast_top.sv
verification/tb_clock_gen.sv
verification/mxint_cast_properties.sv
verification/mxint_cast_tb.sv

// ==== Makefile ====
TOP := mxint_cast_tb

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
